/* rtl/neo_map_pkg.sv */
`default_nettype none

package neo_map_pkg;

	// Download index codes
	localparam logic [7:0] idx_bios = 8'd0;
	localparam logic [7:0] idx_bios_alt = 8'd1;
	localparam logic [7:0] idx_cart = 8'd2;

	// Byte address width of bank 3
	localparam int port1_aw = 24;

	// Bank 3 layout, top bits of the byte address
	// 1111 1xxx  system ROM
	// 1101 111x  LO ROM
	// 1110 100x  SFIX
	// 1110 11xx  SM1
	// 1110 0xxx  FIX ROM
	// 1111 0xxx  Z80 cart ROM
	localparam logic [4:0] map_sysrom = 5'b11111;
	localparam logic [7:0] map_loram = 8'b11011110;
	localparam logic [6:0] map_sfix = 7'b1110100;
	localparam logic [5:0] map_sm1 = 6'b111011;
	localparam logic [4:0] map_fix = 5'b11100;
	localparam logic [4:0] map_mrom = 5'b11110;

	// Prom sits at the bottom of bank 3, so its prefix is just zero

endpackage

`default_nettype wire

/* rtl/neo_cart_pkg.sv */
`default_nettype none

package neo_cart_pkg;

	// Cart header occupies the first 4 KB of the download
	localparam int header_bytes = 4096;

	// Six little-endian 32-bit sizes after the 4-byte magic
	localparam int size_first = 4;
	localparam int size_last = 27;

	typedef logic [2:0] region_t;
	typedef logic [31:0] rom_size_t;

	// Byte address in banks 0 to 2
	typedef logic [25:0] sdram_addr_t;

	// Regions in the order they follow the header
	localparam region_t rgn_prom = 3'd0;
	localparam region_t rgn_srom = 3'd1;
	localparam region_t rgn_mrom = 3'd2;
	localparam region_t rgn_v1 = 3'd3;
	localparam region_t rgn_v2 = 3'd4;
	localparam region_t rgn_crom = 3'd5;

	// Banks 0 to 2 hold crom, then v1, then v2

endpackage

`default_nettype wire

/* rtl/neo_header.sv */
`timescale 1ns/1ps
`default_nettype none

module neo_header #(
	parameter int sample_aw = 24
) (
	input  logic CLK_48M,
	input  logic reset,
	input  logic ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0] ioctl_dout,
	output logic header_done,
	output neo_cart_pkg::rom_size_t p_size,
	output neo_cart_pkg::rom_size_t s_size,
	output neo_cart_pkg::rom_size_t m_size,
	output neo_cart_pkg::rom_size_t v1_size,
	output neo_cart_pkg::rom_size_t v2_size,
	output neo_cart_pkg::rom_size_t c_size,
	output neo_cart_pkg::sdram_addr_t [1:0] chan_base,
	output logic [1:0][sample_aw-1:0] chan_mask
);

	neo_cart_pkg::rom_size_t [5:0] sizes;
	logic cart_write;
	logic last_byte;
	logic pcm_merged;
	logic [sample_aw-1:0] v1_mask;
	logic [sample_aw-1:0] v2_mask;

	// Next power of two at or above size, minus one
	function automatic logic [sample_aw-1:0] ceil_mask(input neo_cart_pkg::rom_size_t size);
		neo_cart_pkg::rom_size_t m;
		m = size - 1'b1;
		for (int i = 30; i >= 0; i--) begin
			m[i] = m[i] | m[i+1];
		end
		if (size == '0) begin
			m = '0;
		end
		return m[sample_aw-1:0];
	endfunction

	assign cart_write = ioctl_download && ioctl_wr && ioctl_index == neo_map_pkg::idx_cart;
	assign last_byte = cart_write && ioctl_addr == 25'(neo_cart_pkg::header_bytes - 1);

	// Size bytes enter at the top, prom size ends up in element 0
	always_ff @(posedge CLK_48M) begin
		if (cart_write && ioctl_addr >= 25'(neo_cart_pkg::size_first) &&
				ioctl_addr <= 25'(neo_cart_pkg::size_last)) begin
			sizes <= {ioctl_dout, sizes[5:1], sizes[0][31:8]};
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (reset) begin
			header_done <= 1'b0;
			pcm_merged <= 1'b0;
		end else begin
			header_done <= last_byte;
			// Some carts pack ADPCM-A and ADPCM-B into v1 alone
			if (last_byte) begin
				pcm_merged <= v2_size == '0;
			end
		end
	end

	assign p_size = sizes[neo_cart_pkg::rgn_prom];
	assign s_size = sizes[neo_cart_pkg::rgn_srom];
	assign m_size = sizes[neo_cart_pkg::rgn_mrom];
	assign v1_size = sizes[neo_cart_pkg::rgn_v1];
	assign v2_size = sizes[neo_cart_pkg::rgn_v2];
	assign c_size = sizes[neo_cart_pkg::rgn_crom];

	assign v1_mask = ceil_mask(v1_size);
	assign v2_mask = ceil_mask(v2_size);

	// Sample data follows crom in banks 0 to 2
	assign chan_base[0] = c_size[25:0];
	assign chan_base[1] = pcm_merged ? c_size[25:0] : c_size[25:0] + v1_size[25:0];
	assign chan_mask[0] = v1_mask;
	assign chan_mask[1] = pcm_merged ? v1_mask : v2_mask;

endmodule

`default_nettype wire

/* rtl/rom_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
	input  logic CLK_48M,
	input  logic reset,
	input  logic ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0] ioctl_dout,
	input  logic header_done,
	input  neo_cart_pkg::rom_size_t p_size,
	input  neo_cart_pkg::rom_size_t s_size,
	input  neo_cart_pkg::rom_size_t m_size,
	input  neo_cart_pkg::rom_size_t v1_size,
	input  neo_cart_pkg::rom_size_t v2_size,
	input  neo_cart_pkg::rom_size_t c_size,
	output logic [neo_map_pkg::port1_aw-2:0] port1_addr,
	output logic [1:0] port1_ds,
	output logic [15:0] port1_d,
	output logic port1_we,
	output logic port1_req,
	input  logic port1_ack,
	output logic [24:0] port2_addr,
	output logic [1:0] port2_ds,
	output logic [15:0] port2_d,
	output logic port2_we,
	output logic port2_req,
	input  logic port2_ack,
	output logic ready_for_byte
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_ack = 2'd1;
	localparam logic [1:0] st_check = 2'd2;

	logic [1:0] state;
	neo_cart_pkg::region_t region;
	neo_cart_pkg::sdram_addr_t offset;
	neo_cart_pkg::sdram_addr_t region_size;
	logic sys_pending;
	logic sys_write;
	logic data_write;
	logic p1_write;
	logic p2_write;
	logic ack_match;
	logic [neo_map_pkg::port1_aw-1:0] sys_p1;
	logic [neo_map_pkg::port1_aw-1:0] cart_p1;
	logic [neo_map_pkg::port1_aw-1:0] p1_byte;
	neo_cart_pkg::sdram_addr_t p2_byte;

	assign sys_write = ioctl_download && ioctl_wr &&
		(ioctl_index == neo_map_pkg::idx_bios || ioctl_index == neo_map_pkg::idx_bios_alt);
	assign data_write = ioctl_download && ioctl_wr && ioctl_index == neo_map_pkg::idx_cart &&
		ioctl_addr >= 25'(neo_cart_pkg::header_bytes);
	assign p1_write = state == st_idle && (sys_write || (data_write && region <= neo_cart_pkg::rgn_mrom));
	assign p2_write = state == st_idle && data_write && region > neo_cart_pkg::rgn_mrom;

	assign ack_match = (sys_pending || region <= neo_cart_pkg::rgn_mrom) ?
		port1_req == port1_ack : port2_req == port2_ack;

	always_comb begin
		case (region)
			neo_cart_pkg::rgn_prom: region_size = p_size[25:0];
			neo_cart_pkg::rgn_srom: region_size = s_size[25:0];
			neo_cart_pkg::rgn_mrom: region_size = m_size[25:0];
			neo_cart_pkg::rgn_v1: region_size = v1_size[25:0];
			neo_cart_pkg::rgn_v2: region_size = v2_size[25:0];
			neo_cart_pkg::rgn_crom: region_size = c_size[25:0];
			default: region_size = '0;
		endcase
	end

	// System ROM file holds sysrom, LO ROM, SFIX and SM1 back to back
	always_comb begin
		if (ioctl_addr[23:19] == 5'd0)
			sys_p1 = {neo_map_pkg::map_sysrom, ioctl_addr[18:0]};
		else if (ioctl_addr[23:17] == 7'b0000100)
			sys_p1 = {neo_map_pkg::map_loram, ioctl_addr[15:0]};
		else if (ioctl_addr[23:17] == 7'b0000101)
			sys_p1 = {neo_map_pkg::map_sfix, ioctl_addr[16:5], ioctl_addr[2:0],
				~ioctl_addr[4], ioctl_addr[3]};
		else
			sys_p1 = {neo_map_pkg::map_sm1, ioctl_addr[17:0]};
	end

	always_comb begin
		case (region)
			// Fix tiles reordered for column fetch
			neo_cart_pkg::rgn_srom: cart_p1 = {neo_map_pkg::map_fix, offset[18:5], offset[2:0],
				~offset[4], offset[3]};
			neo_cart_pkg::rgn_mrom: cart_p1 = {neo_map_pkg::map_mrom, offset[18:0]};
			default: cart_p1 = offset[neo_map_pkg::port1_aw-1:0];
		endcase
	end

	assign p1_byte = sys_write ? sys_p1 : cart_p1;

	always_comb begin
		case (region)
			neo_cart_pkg::rgn_v1: p2_byte = c_size[25:0] + offset;
			neo_cart_pkg::rgn_v2: p2_byte = c_size[25:0] + v1_size[25:0] + offset;
			// Interleave the odd and even crom files into one 32-bit word
			default: p2_byte = {offset[25:7], ioctl_addr[5:2], ~ioctl_addr[6],
				ioctl_addr[0], ioctl_addr[1]};
		endcase
	end

	always_ff @(posedge CLK_48M) begin
		if (p1_write) begin
			port1_addr <= p1_byte[neo_map_pkg::port1_aw-1:1];
			port1_ds <= {p1_byte[0], ~p1_byte[0]};
			port1_d <= {ioctl_dout, ioctl_dout};
		end
		if (p2_write) begin
			port2_addr <= p2_byte[25:1];
			port2_ds <= {p2_byte[0], ~p2_byte[0]};
			port2_d <= {ioctl_dout, ioctl_dout};
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (reset) begin
			state <= st_idle;
			region <= neo_cart_pkg::rgn_prom;
			offset <= '0;
			sys_pending <= 1'b0;
			port1_req <= 1'b0;
			port2_req <= 1'b0;
			port1_we <= 1'b0;
			port2_we <= 1'b0;
		end else begin
			if (!ioctl_download) begin
				port1_we <= 1'b0;
				port2_we <= 1'b0;
			end
			if (header_done) begin
				region <= neo_cart_pkg::rgn_prom;
				offset <= '0;
				state <= st_check;
			end else begin
				case (state)
					st_idle: begin
						if (p1_write) begin
							port1_req <= ~port1_req;
							port1_we <= 1'b1;
							sys_pending <= sys_write;
							state <= st_ack;
						end else if (p2_write) begin
							port2_req <= ~port2_req;
							port2_we <= 1'b1;
							sys_pending <= 1'b0;
							state <= st_ack;
						end
					end
					st_ack: begin
						if (ack_match) begin
							if (sys_pending) begin
								state <= st_idle;
							end else begin
								offset <= offset + 1'b1;
								state <= st_check;
							end
						end
					end
					st_check: begin
						// Empty regions fall through one per cycle
						if (offset == region_size) begin
							offset <= '0;
							region <= region + 1'b1;
							if (region == neo_cart_pkg::rgn_crom)
								state <= st_idle;
						end else begin
							state <= st_idle;
						end
					end
					default: state <= st_idle;
				endcase
			end
		end
	end

	assign ready_for_byte = state == st_idle && !header_done;

endmodule

`default_nettype wire

/* rtl/sample_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_fetch #(
	parameter int sample_aw = 24
) (
	input  logic CLK_48M,
	input  logic reset,
	input  logic rd,
	input  logic [sample_aw-1:0] addr,
	input  neo_cart_pkg::sdram_addr_t base,
	input  logic [sample_aw-1:0] mask,
	output logic sample_req,
	input  logic sample_ack,
	output neo_cart_pkg::sdram_addr_t sample_addr,
	input  logic [31:0] sample_dout,
	output logic [7:0] data,
	output logic ready
);

	logic rd_d;
	logic rd_rise;
	logic have_word;
	logic [sample_aw-1:0] masked;
	logic [sample_aw-1:0] latch;

	assign rd_rise = rd && !rd_d;

	// Wrap the address inside the region
	assign masked = addr & mask;

	always_ff @(posedge CLK_48M) begin
		if (reset) begin
			rd_d <= 1'b0;
			have_word <= 1'b0;
			sample_req <= 1'b0;
		end else begin
			rd_d <= rd;
			if (rd_rise) begin
				have_word <= 1'b1;
				// Same 32-bit word already fetched
				if (!have_word || latch[sample_aw-1:2] != masked[sample_aw-1:2])
					sample_req <= ~sample_req;
			end
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (rd_rise)
			latch <= masked;
	end

	assign sample_addr = base + neo_cart_pkg::sdram_addr_t'(latch);
	assign ready = sample_req == sample_ack;

	// Byte lane from the low address bits
	assign data = sample_dout[{latch[1:0], 3'b000} +: 8];

endmodule

`default_nettype wire

/* rtl/cart_rom_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_rom_top #(
	parameter int sample_aw = 24
) (
	input  logic CLK_48M,
	input  logic reset,
	input  logic ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0] ioctl_dout,
	output logic [neo_map_pkg::port1_aw-2:0] port1_addr,
	output logic [1:0] port1_ds,
	output logic [15:0] port1_d,
	output logic port1_we,
	output logic port1_req,
	input  logic port1_ack,
	output logic [24:0] port2_addr,
	output logic [1:0] port2_ds,
	output logic [15:0] port2_d,
	output logic port2_we,
	output logic port2_req,
	input  logic port2_ack,
	output logic ready_for_byte,
	input  logic [19:0] adpcma_addr,
	input  logic [3:0] adpcma_bank,
	input  logic adpcma_rd,
	input  logic [23:0] adpcmb_addr,
	input  logic adpcmb_rd,
	output logic [1:0] sample_req,
	input  logic [1:0] sample_ack,
	output neo_cart_pkg::sdram_addr_t [1:0] sample_addr,
	input  logic [1:0][31:0] sample_dout,
	output logic [1:0][7:0] adpcm_data,
	output logic [1:0] adpcm_ready
);

	logic header_done;
	neo_cart_pkg::rom_size_t p_size;
	neo_cart_pkg::rom_size_t s_size;
	neo_cart_pkg::rom_size_t m_size;
	neo_cart_pkg::rom_size_t v1_size;
	neo_cart_pkg::rom_size_t v2_size;
	neo_cart_pkg::rom_size_t c_size;
	neo_cart_pkg::sdram_addr_t [1:0] chan_base;
	logic [1:0][sample_aw-1:0] chan_mask;
	logic [1:0] chan_rd;
	logic [1:0][sample_aw-1:0] chan_addr;

	assign chan_rd = {adpcmb_rd, adpcma_rd};
	assign chan_addr[0] = sample_aw'({adpcma_bank, adpcma_addr});
	// ADPCM-B has no bank, upper bits stay zero
	assign chan_addr[1] = sample_aw'(adpcmb_addr);

	neo_header #(.sample_aw(sample_aw)) u_header (
		.CLK_48M(CLK_48M), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.header_done(header_done),
		.p_size(p_size), .s_size(s_size), .m_size(m_size),
		.v1_size(v1_size), .v2_size(v2_size), .c_size(c_size),
		.chan_base(chan_base), .chan_mask(chan_mask)
	);

	rom_loader u_loader (
		.CLK_48M(CLK_48M), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.header_done(header_done),
		.p_size(p_size), .s_size(s_size), .m_size(m_size),
		.v1_size(v1_size), .v2_size(v2_size), .c_size(c_size),
		.port1_addr(port1_addr), .port1_ds(port1_ds), .port1_d(port1_d),
		.port1_we(port1_we), .port1_req(port1_req), .port1_ack(port1_ack),
		.port2_addr(port2_addr), .port2_ds(port2_ds), .port2_d(port2_d),
		.port2_we(port2_we), .port2_req(port2_req), .port2_ack(port2_ack),
		.ready_for_byte(ready_for_byte)
	);

	for (genvar i = 0; i < 2; i++) begin : g_chan
		sample_fetch #(.sample_aw(sample_aw)) u_fetch (
			.CLK_48M(CLK_48M), .reset(reset),
			.rd(chan_rd[i]), .addr(chan_addr[i]),
			.base(chan_base[i]), .mask(chan_mask[i]),
			.sample_req(sample_req[i]), .sample_ack(sample_ack[i]),
			.sample_addr(sample_addr[i]), .sample_dout(sample_dout[i]),
			.data(adpcm_data[i]), .ready(adpcm_ready[i])
		);
	end

endmodule

`default_nettype wire

/* testbench/tb_cart_tasks.svh */
`ifndef TB_CART_TASKS_SVH
`define TB_CART_TASKS_SVH

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic logic [23:0] pow2_mask(input neo_cart_pkg::rom_size_t size);
	logic [31:0] m;
	m = 1;
	while (m < size)
		m = m << 1;
	return (size == 0) ? 24'd0 : 24'(m - 1);
endfunction

task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
	$display("TEST RESULT: FAIL");
	$fatal(1);
endtask

task automatic check_word(input string name, input neo_cart_pkg::rom_size_t got,
		input neo_cart_pkg::rom_size_t exp);
	if (got !== exp)
		fail_value(name, got, exp);
endtask

task automatic check_addr(input string name, input neo_cart_pkg::sdram_addr_t got,
		input neo_cart_pkg::sdram_addr_t exp);
	if (got !== exp)
		fail_value(name, 32'(got), 32'(exp));
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
		fail_value(name, 32'(got), 32'(exp));
endtask

task automatic wait_ready();
	while (!ready_for_byte)
		@(negedge CLK_48M);
endtask

task automatic write_byte(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
	wait_ready();
	ioctl_index = index;
	ioctl_addr = addr;
	ioctl_dout = data;
	ioctl_wr = 1'b1;
	@(negedge CLK_48M);
	ioctl_wr = 1'b0;
	wait_ready();
endtask

// Expected byte address splits into word address and byte select
task automatic expect_port1(input logic [23:0] byte_addr, input logic [7:0] data);
	if (p1_addr_q.size() != 1 || p2_addr_q.size() != 0) begin
		$display("Port 1 write expected alone, saw %0d on port 1 and %0d on port 2",
			p1_addr_q.size(), p2_addr_q.size());
		$display("TEST RESULT: FAIL");
		$fatal(1);
	end
	check_addr("port1_addr", 26'(p1_addr_q.pop_front()), 26'(byte_addr[23:1]));
	check_byte("port1_ds", 8'(p1_ds_q.pop_front()), 8'({byte_addr[0], ~byte_addr[0]}));
	check_word("port1_d", 32'(p1_d_q.pop_front()), {16'd0, data, data});
	check_byte("port1_we", 8'(port1_we), 8'd1);
endtask

task automatic expect_port2(input neo_cart_pkg::sdram_addr_t byte_addr, input logic [7:0] data);
	if (p2_addr_q.size() != 1 || p1_addr_q.size() != 0) begin
		$display("Port 2 write expected alone, saw %0d on port 2 and %0d on port 1",
			p2_addr_q.size(), p1_addr_q.size());
		$display("TEST RESULT: FAIL");
		$fatal(1);
	end
	check_addr("port2_addr", 26'(p2_addr_q.pop_front()), 26'(byte_addr[25:1]));
	check_byte("port2_ds", 8'(p2_ds_q.pop_front()), 8'({byte_addr[0], ~byte_addr[0]}));
	check_word("port2_d", 32'(p2_d_q.pop_front()), {16'd0, data, data});
	check_byte("port2_we", 8'(port2_we), 8'd1);
endtask

task automatic load_header(input neo_cart_pkg::rom_size_t sizes [6]);
	logic [7:0] b;
	for (int a = 0; a < neo_cart_pkg::header_bytes; a++) begin
		b = 8'd0;
		if (a >= 4 && a <= 27)
			b = sizes[(a - 4) / 4][8 * ((a - 4) % 4) +: 8];
		write_byte(neo_map_pkg::idx_cart, 25'(a), b);
	end
	repeat (2) @(negedge CLK_48M);
	wait_ready();
	check_word("v1_size", DUT.u_header.v1_size, sizes[3]);
	check_word("v2_size", DUT.u_header.v2_size, sizes[4]);
endtask

task automatic read_sample(input int ch, input logic [23:0] addr,
		input neo_cart_pkg::sdram_addr_t base, input logic [23:0] mask, input bit fetch);
	int unsigned count_before;
	logic [23:0] masked;
	count_before = sample_count[ch];
	masked = addr & mask;
	if (ch == 0) begin
		adpcma_bank = addr[23:20];
		adpcma_addr = addr[19:0];
		adpcma_rd = 1'b1;
	end else begin
		adpcmb_addr = addr;
		adpcmb_rd = 1'b1;
	end
	@(negedge CLK_48M);
	adpcma_rd = 1'b0;
	adpcmb_rd = 1'b0;
	@(negedge CLK_48M);
	while (!adpcm_ready[ch])
		@(negedge CLK_48M);
	check_word("sample request count", sample_count[ch], count_before + (fetch ? 1 : 0));
	check_addr("sample_addr", sample_addr[ch], base + 26'(masked));
	check_byte("adpcm_data", adpcm_data[ch], model_word[ch][8 * masked[1:0] +: 8]);
endtask

task automatic test_reset_state();
	check_byte("port1_req", 8'(port1_req), 8'd0);
	check_byte("port2_req", 8'(port2_req), 8'd0);
	check_byte("sample_req", 8'(sample_req), 8'd0);
	check_byte("port1_we", 8'(port1_we), 8'd0);
	check_byte("port2_we", 8'(port2_we), 8'd0);
	check_byte("ready_for_byte", 8'(ready_for_byte), 8'd1);
	check_byte("adpcm_ready", 8'(adpcm_ready), 8'd3);
endtask

task automatic test_bios_write();
	logic [24:0] a;
	a = 25'h01235;
	write_byte(neo_map_pkg::idx_bios, a, 8'ha5);
	expect_port1({neo_map_pkg::map_sysrom, a[18:0]}, 8'ha5);
endtask

// Header A: p 4, s 32, m 4, v1 6, v2 10, c 0x1000
task automatic test_cart_port1();
	neo_cart_pkg::rom_size_t sizes [6];
	logic [25:0] o;
	logic [7:0] d;
	sizes = '{32'd4, 32'd32, 32'd4, 32'd6, 32'd10, 32'h1000};
	load_header(sizes);
	for (int i = 0; i < 40; i++) begin
		d = 8'(lcg_next());
		write_byte(neo_map_pkg::idx_cart, 25'(4096 + i), d);
		if (i < 4) begin
			expect_port1(24'(i), d);
		end else if (i < 36) begin
			o = 26'(i - 4);
			expect_port1({neo_map_pkg::map_fix, o[18:5], o[2:0], ~o[4], o[3]}, d);
		end else begin
			o = 26'(i - 36);
			expect_port1({neo_map_pkg::map_mrom, o[18:0]}, d);
		end
	end
endtask

task automatic test_cart_port2();
	logic [7:0] d;
	for (int i = 0; i < 16; i++) begin
		d = 8'(lcg_next());
		write_byte(neo_map_pkg::idx_cart, 25'(4136 + i), d);
		if (i < 6)
			expect_port2(26'h1000 + 26'(i), d);
		else
			expect_port2(26'h1000 + 26'd6 + 26'(i - 6), d);
	end
endtask

task automatic test_sample_split();
	read_sample(0, 24'h000013, 26'h1000, pow2_mask(32'd6), 1'b1);
	read_sample(0, 24'h000011, 26'h1000, pow2_mask(32'd6), 1'b0);
	read_sample(1, 24'h000009, 26'h1006, pow2_mask(32'd10), 1'b1);
endtask

// Header B: s and m empty so v1 follows prom, v2 empty so PCM is merged
task automatic test_sample_merged();
	neo_cart_pkg::rom_size_t sizes [6];
	logic [7:0] d;
	sizes = '{32'd2, 32'd0, 32'd0, 32'd6, 32'd0, 32'h1000};
	load_header(sizes);
	for (int i = 0; i < 8; i++) begin
		d = 8'(lcg_next());
		write_byte(neo_map_pkg::idx_cart, 25'(4096 + i), d);
		if (i < 2)
			expect_port1(24'(i), d);
		else
			expect_port2(26'h1000 + 26'(i - 2), d);
	end
	read_sample(1, 24'h00000e, 26'h1000, pow2_mask(32'd6), 1'b1);
endtask

`endif

/* testbench/tb_cart_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cart_rom;

	// Two 4 KB headers at up to four cycles a byte, plus data and sample reads,
	// with a wide margin on top
	localparam int watchdog_cycles = 200_000;

	logic CLK_48M;
	logic reset;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic [22:0] port1_addr;
	logic [1:0] port1_ds;
	logic [15:0] port1_d;
	logic port1_we;
	logic port1_req;
	logic port1_ack;
	logic [24:0] port2_addr;
	logic [1:0] port2_ds;
	logic [15:0] port2_d;
	logic port2_we;
	logic port2_req;
	logic port2_ack;
	logic ready_for_byte;
	logic [19:0] adpcma_addr;
	logic [3:0] adpcma_bank;
	logic adpcma_rd;
	logic [23:0] adpcmb_addr;
	logic adpcmb_rd;
	logic [1:0] sample_req;
	logic [1:0] sample_ack;
	neo_cart_pkg::sdram_addr_t [1:0] sample_addr;
	logic [1:0][31:0] sample_dout;
	logic [1:0][7:0] adpcm_data;
	logic [1:0] adpcm_ready;

	// SDRAM model state indexed port1, port2, then the two sample channels
	logic [3:0] ack_r;
	logic [3:0] req_v;
	logic [3:0] req_seen;
	int unsigned wait_cnt [4];
	logic [31:0] lcg_state;
	logic [31:0] model_word [2];
	int unsigned sample_count [2];
	logic [22:0] p1_addr_q [$];
	logic [1:0] p1_ds_q [$];
	logic [15:0] p1_d_q [$];
	logic [24:0] p2_addr_q [$];
	logic [1:0] p2_ds_q [$];
	logic [15:0] p2_d_q [$];

	assign port1_ack = ack_r[0];
	assign port2_ack = ack_r[1];
	assign sample_ack = ack_r[3:2];
	assign req_v = {sample_req, port2_req, port1_req};

	cart_rom_top #(.sample_aw(24)) DUT (
		.CLK_48M(CLK_48M), .reset(reset),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.port1_addr(port1_addr), .port1_ds(port1_ds), .port1_d(port1_d),
		.port1_we(port1_we), .port1_req(port1_req), .port1_ack(port1_ack),
		.port2_addr(port2_addr), .port2_ds(port2_ds), .port2_d(port2_d),
		.port2_we(port2_we), .port2_req(port2_req), .port2_ack(port2_ack),
		.ready_for_byte(ready_for_byte),
		.adpcma_addr(adpcma_addr), .adpcma_bank(adpcma_bank), .adpcma_rd(adpcma_rd),
		.adpcmb_addr(adpcmb_addr), .adpcmb_rd(adpcmb_rd),
		.sample_req(sample_req), .sample_ack(sample_ack), .sample_addr(sample_addr),
		.sample_dout(sample_dout), .adpcm_data(adpcm_data), .adpcm_ready(adpcm_ready)
	);

	`include "tb_cart_tasks.svh"

	initial begin
		CLK_48M = 1'b0;
		forever #50 CLK_48M = ~CLK_48M;
	end

	// SDRAM model records each new request and acks it 1 to 4 cycles later
	always @(negedge CLK_48M) begin
		logic [31:0] word;
		if (reset) begin
			ack_r <= '0;
			req_seen <= '0;
			for (int i = 0; i < 4; i++)
				wait_cnt[i] = 0;
		end else begin
			if (port1_req != req_seen[0]) begin
				p1_addr_q.push_back(port1_addr);
				p1_ds_q.push_back(port1_ds);
				p1_d_q.push_back(port1_d);
			end
			if (port2_req != req_seen[1]) begin
				p2_addr_q.push_back(port2_addr);
				p2_ds_q.push_back(port2_ds);
				p2_d_q.push_back(port2_d);
			end
			for (int i = 0; i < 2; i++) begin
				if (sample_req[i] != req_seen[2+i]) begin
					word = lcg_next();
					sample_dout[i] <= word;
					model_word[i] = word;
					sample_count[i]++;
				end
			end
			req_seen <= req_v;
			for (int i = 0; i < 4; i++) begin
				if (req_v[i] != ack_r[i]) begin
					if (wait_cnt[i] == 0)
						wait_cnt[i] = 1 + lcg_next() % 4;
					wait_cnt[i]--;
					if (wait_cnt[i] == 0)
						ack_r[i] <= ~ack_r[i];
				end
			end
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge CLK_48M);
		$display("Timeout: the DUT stopped answering before the tests completed");
		$display("TEST RESULT: FAIL");
		$fatal(1);
	end

	initial begin
		lcg_state = 32'hdd85135b;
		ack_r = '0;
		req_seen = '0;
		sample_dout = '0;
		sample_count[0] = 0;
		sample_count[1] = 0;
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		adpcma_addr = '0;
		adpcma_bank = '0;
		adpcma_rd = 1'b0;
		adpcmb_addr = '0;
		adpcmb_rd = 1'b0;
		repeat (5) @(negedge CLK_48M);
		reset = 1'b0;
		ioctl_download = 1'b1;
		@(negedge CLK_48M);
		test_reset_state();
		test_bios_write();
		test_cart_port1();
		test_cart_port2();
		test_sample_split();
		test_sample_merged();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+testbench
rtl/neo_map_pkg.sv
rtl/neo_cart_pkg.sv
rtl/neo_header.sv
rtl/rom_loader.sv
rtl/sample_fetch.sv
rtl/cart_rom_top.sv
testbench/tb_cart_rom.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cart ROM testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_cart_rom \
	-Mdir obj_dir -o tb_cart_rom
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_cart_rom 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi
